// ==== Bender.yml ====
package:
  name: ecc_secded

sources:
  - include_dirs:
      - logic
    files:
      - logic/ecc_pkg.sv
      - logic/ecc_encoder.sv
      - logic/ecc_syndrome_decoder.sv
      - logic/ecc_checker.sv
      - logic/ecc_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - testbench/ecc_tb.sv

// ==== list.f ====
+incdir+logic
logic/ecc_pkg.sv
logic/ecc_encoder.sv
logic/ecc_syndrome_decoder.sv
logic/ecc_checker.sv
logic/ecc_top.sv
testbench/ecc_tb.sv

// ==== logic/ecc_checker.sv ====
`timescale 1ns/1ps

module ecc_checker
    import ecc_pkg::*;
(
    input  logic           clk,
    input  logic           arst_n,
    input  logic           in_valid,
    input  ecc_check_req_t req,
    input  ecc_check_t     computed,
    output logic           out_valid,
    output ecc_result_t    result
);

    ecc_check_req_t req_q;
    ecc_check_t     computed_q;
    logic           valid_q;

    ecc_syndrome_t  syndrome;
    ecc_data_t      mask;
    ecc_err_e       err;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= in_valid;
        end
    end

    // The stage only loads on a valid word and holds otherwise.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_q      <= '0;
            computed_q <= '0;
        end else if (in_valid) begin
            req_q      <= req;
            computed_q <= computed;
        end
    end

    assign syndrome = req_q.check ^ computed_q;

    ecc_syndrome_decoder u_ecc_syndrome_decoder (
        .syndrome (syndrome),
        .mask     (mask),
        .err      (err)
    );

    always_comb begin
        if (req_q.bypass) begin
            result.data = req_q.data;   // Raw word, no correction.
            result.err  = ECC_ERR_NONE;
        end else begin
            result.data = req_q.data ^ mask;
            result.err  = err;
        end
    end

    assign out_valid = valid_q;

endmodule

// ==== logic/ecc_encoder.sv ====
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_encoder
    import ecc_pkg::*;
(
    input  ecc_data_t  data,
    output ecc_check_t check
);

    // Each check bit is the parity of the data bits whose column has that bit set.
    always_comb begin
        check = '0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            for (int j = 0; j < `ECC_CHECK_WIDTH; j++) begin
                check[j] = check[j] ^ (data[i] & ecc_h_column[i][j]);
            end
        end
    end

endmodule

// ==== logic/ecc_params.svh ====
`ifndef ECC_PARAMS_SVH
`define ECC_PARAMS_SVH

// Width of the protected data word.
`define ECC_DATA_WIDTH 101

// Number of check bits; 7 Hamming bits plus one overall parity bit.
`define ECC_CHECK_WIDTH 8

`endif

// ==== logic/ecc_pkg.sv ====
`include "ecc_params.svh"

package ecc_pkg;

    typedef logic [`ECC_DATA_WIDTH-1:0]  ecc_data_t;
    typedef logic [`ECC_CHECK_WIDTH-1:0] ecc_check_t;
    typedef logic [`ECC_CHECK_WIDTH-1:0] ecc_syndrome_t;

    // Bit 0 flags a single error and bit 1 a double error.
    typedef enum logic [1:0] {
        ECC_ERR_NONE   = 2'd0,
        ECC_ERR_SINGLE = 2'd1,
        ECC_ERR_DOUBLE = 2'd2
    } ecc_err_e;

    typedef struct packed {
        ecc_data_t  data;
        ecc_check_t check;   // Check bits stored with the word.
        logic       bypass;
    } ecc_check_req_t;

    typedef struct packed {
        ecc_data_t data;
        ecc_err_e  err;
    } ecc_result_t;

    // Column i is the syndrome that a flip of data bit i produces.
    // All data columns have odd weight, so they never collide with a
    // one-hot check-bit column or with the sum of two other columns.
    localparam ecc_check_t ecc_h_column [`ECC_DATA_WIDTH] = '{
        0:   8'b1000_0011,
        1:   8'b1000_0101,
        2:   8'b1000_0110,
        3:   8'b0000_0111,
        4:   8'b1000_1001,
        5:   8'b1000_1010,
        6:   8'b0000_1011,
        7:   8'b1000_1100,
        8:   8'b0000_1101,
        9:   8'b0000_1110,
        10:  8'b1000_1111,
        11:  8'b1001_0001,
        12:  8'b1001_0010,
        13:  8'b0001_0011,
        14:  8'b1001_0100,
        15:  8'b0001_0101,
        16:  8'b0001_0110,
        17:  8'b1001_0111,
        18:  8'b1001_1000,
        19:  8'b0001_1001,
        20:  8'b0001_1010,
        21:  8'b1001_1011,
        22:  8'b0001_1100,
        23:  8'b1001_1101,
        24:  8'b1001_1110,
        25:  8'b0001_1111,
        26:  8'b1010_0001,
        27:  8'b1010_0010,
        28:  8'b0010_0011,
        29:  8'b1010_0100,
        30:  8'b0010_0101,
        31:  8'b0010_0110,
        32:  8'b1010_0111,
        33:  8'b1010_1000,
        34:  8'b0010_1001,
        35:  8'b0010_1010,
        36:  8'b1010_1011,
        37:  8'b0010_1100,
        38:  8'b1010_1101,
        39:  8'b1010_1110,
        40:  8'b0010_1111,
        41:  8'b1011_0000,
        42:  8'b0011_0001,
        43:  8'b0011_0010,
        44:  8'b1011_0011,
        45:  8'b0011_0100,
        46:  8'b1011_0101,
        47:  8'b1011_0110,
        48:  8'b0011_0111,
        49:  8'b0011_1000,
        50:  8'b1011_1001,
        51:  8'b1011_1010,
        52:  8'b0011_1011,
        53:  8'b1011_1100,
        54:  8'b0011_1101,
        55:  8'b0011_1110,
        56:  8'b1011_1111,
        57:  8'b1100_0001,
        58:  8'b1100_0010,
        59:  8'b0100_0011,
        60:  8'b1100_0100,
        61:  8'b0100_0101,
        62:  8'b0100_0110,
        63:  8'b1100_0111,
        64:  8'b1100_1000,
        65:  8'b0100_1001,
        66:  8'b0100_1010,
        67:  8'b1100_1011,
        68:  8'b0100_1100,
        69:  8'b1100_1101,
        70:  8'b1100_1110,
        71:  8'b0100_1111,
        72:  8'b1101_0000,
        73:  8'b0101_0001,
        74:  8'b0101_0010,
        75:  8'b1101_0011,
        76:  8'b0101_0100,
        77:  8'b1101_0101,
        78:  8'b1101_0110,
        79:  8'b0101_0111,
        80:  8'b0101_1000,
        81:  8'b1101_1001,
        82:  8'b1101_1010,
        83:  8'b0101_1011,
        84:  8'b1101_1100,
        85:  8'b0101_1101,
        86:  8'b0101_1110,
        87:  8'b1101_1111,
        88:  8'b1110_0000,
        89:  8'b0110_0001,
        90:  8'b0110_0010,
        91:  8'b1110_0011,
        92:  8'b0110_0100,
        93:  8'b1110_0101,
        94:  8'b1110_0110,
        95:  8'b0110_0111,
        96:  8'b0110_1000,
        97:  8'b1110_1001,
        98:  8'b1110_1010,
        99:  8'b0110_1011,
        100: 8'b1110_1100
    };

endpackage

// ==== logic/ecc_syndrome_decoder.sv ====
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_syndrome_decoder
    import ecc_pkg::*;
(
    input  ecc_syndrome_t syndrome,
    output ecc_data_t     mask,
    output ecc_err_e      err
);

    logic column_hit;   // Syndrome matches a data column.
    logic check_hit;    // Syndrome is one-hot, so only a check bit flipped.

    assign check_hit = (syndrome != '0) && ((syndrome & (syndrome - 1'b1)) == '0);

    always_comb begin
        mask       = '0;
        column_hit = 1'b0;
        for (int i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (syndrome == ecc_h_column[i]) begin
                mask[i]    = 1'b1;
                column_hit = 1'b1;
            end
        end
    end

    always_comb begin
        if (syndrome == '0) begin
            err = ECC_ERR_NONE;
        end else if (column_hit || check_hit) begin
            err = ECC_ERR_SINGLE;   // Data bit corrected or check bit flagged.
        end else begin
            err = ECC_ERR_DOUBLE;   // Even weight, not correctable.
        end
    end

endmodule

// ==== logic/ecc_top.sv ====
`timescale 1ns/1ps

module ecc_top
    import ecc_pkg::*;
(
    input  logic       clk,
    input  logic       arst_n,
    input  logic       in_valid,
    input  ecc_data_t  data_in,
    input  ecc_check_t check_in,
    input  logic       bypass,
    output ecc_check_t check_out,
    output logic       out_valid,
    output ecc_data_t  data_out,
    output logic       sbit_err,
    output logic       dbit_err
);

    ecc_check_req_t req;
    ecc_check_t     computed;
    ecc_result_t    result;

    assign req = '{data: data_in, check: check_in, bypass: bypass};

    // Check bits for the incoming word, also used to write fresh words.
    ecc_encoder u_ecc_encoder (
        .data  (data_in),
        .check (computed)
    );

    assign check_out = computed;

    ecc_checker u_ecc_checker (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .req       (req),
        .computed  (computed),
        .out_valid (out_valid),
        .result    (result)
    );

    assign data_out = result.data;
    assign sbit_err = (result.err == ECC_ERR_SINGLE);
    assign dbit_err = (result.err == ECC_ERR_DOUBLE);

endmodule

// ==== testbench/ecc_stim.txt ====
# data (hex, 101 bits)  check (hex)  flip_a  flip_b  bypass
# flip: -1 none, 0..100 data bit, 101..108 check bit 0..7
00000000000000000000000000 00 -1 -1 0
00000000000000000000000001 83 -1 -1 0
10000000000000000000000000 EC -1 -1 0
00000000000000000000000003 06 -1 -1 0
0000000000000000000000000F 87 -1 -1 0
000000000000000000000000FF 03 -1 -1 0
0000000000000000000000FFFF 1E -1 -1 0
00000000000004000000000000 B9 -1 -1 0
00000000010000000000000000 C8 -1 -1 0
10000000000000000000000001 6F -1 -1 0
00000000010004000000000000 71 -1 -1 0
1000000000000000000000FFFF F2 -1 -1 0
00000000000000000000000000 00 0 -1 0
00000000000000000000000000 00 100 -1 0
0000000000000000000000FFFF 1E 7 -1 0
10000000000000000000000000 EC 100 -1 0
00000000010004000000000000 71 64 -1 0
1000000000000000000000FFFF F2 55 -1 0
00000000000000000000000001 83 101 -1 0
000000000000000000000000FF 03 108 -1 0
0000000000000000000000000F 87 104 -1 0
00000000000000000000000000 00 0 100 0
0000000000000000000000FFFF 1E 3 9 0
00000000010000000000000000 C8 20 105 0
00000000000004000000000000 B9 101 102 0
10000000000000000000000001 6F 0 100 0
00000000000000000000000001 83 -1 -1 1
000000000000000000000000FF 03 5 -1 1
1000000000000000000000FFFF F2 10 106 1

// ==== testbench/ecc_tb.sv ====
`timescale 1ns/1ps
`include "ecc_params.svh"

module ecc_tb
    import ecc_pkg::*;
();

    localparam int FLIP_LIMIT   = `ECC_DATA_WIDTH + `ECC_CHECK_WIDTH;
    localparam int RANDOM_WORDS = 16;
    localparam int MAX_LINES    = 1000;
    localparam int WAIT_LIMIT   = 20;

    typedef struct packed {
        ecc_data_t data;
        logic      sbit;
        logic      dbit;
    } expect_t;

    logic       clk;
    logic       arst_n;
    logic       in_valid;
    ecc_data_t  data_in;
    ecc_check_t check_in;
    logic       bypass;
    ecc_check_t check_out;
    logic       out_valid;
    ecc_data_t  data_out;
    logic       sbit_err;
    logic       dbit_err;

    ecc_check_t h_col [`ECC_DATA_WIDTH];
    integer     seed;
    integer     errors;
    integer     tests_run;
    integer     tests_failed;
    integer     words_read;

    // The word that sits in the register stage and is checked one slot later.
    logic       pend_valid;
    string      pend_name;
    expect_t    pend_exp;
    integer     pend_errors;

    ecc_top u_ecc_top (
        .clk       (clk),
        .arst_n    (arst_n),
        .in_valid  (in_valid),
        .data_in   (data_in),
        .check_in  (check_in),
        .bypass    (bypass),
        .check_out (check_out),
        .out_valid (out_valid),
        .data_out  (data_out),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err)
    );

    always #20 clk = ~clk;

    // Extended Hamming code: positions 3 to 108 that are not powers of two,
    // with the top bit as overall parity so every column has odd weight.
    task automatic build_columns();
        int         pos;
        int         idx;
        logic [6:0] low;
        pos = 3;
        idx = 0;
        while (idx < `ECC_DATA_WIDTH) begin
            low = pos[6:0];
            if ((low & (low - 7'd1)) != 7'd0) begin
                h_col[idx] = {~(^low), low};
                idx++;
            end
            pos++;
        end
    endtask

    function automatic ecc_check_t encode(input ecc_data_t d);
        ecc_check_t c;
        int         i;
        c = '0;
        for (i = 0; i < `ECC_DATA_WIDTH; i++) begin
            if (d[i]) begin
                c = c ^ h_col[i];
            end
        end
        return c;
    endfunction

    function automatic expect_t make_expect(input ecc_data_t d, input logic s, input logic db);
        expect_t e;
        e.data = d;
        e.sbit = s;
        e.dbit = db;
        return e;
    endfunction

    task automatic compare(input string name, input logic [127:0] actual,
                           input logic [127:0] expected);
        if (actual !== expected) begin
            $display("FAILED %s: got 0x%0h, expected 0x%0h", name, actual, expected);
            errors++;
        end
    endtask

    // Positions past the data word land in the check bits.
    task automatic apply_flip(input integer pos, inout ecc_data_t d, inout ecc_check_t c);
        if (pos >= 0 && pos < `ECC_DATA_WIDTH) begin
            d[pos] = ~d[pos];
        end else if (pos >= `ECC_DATA_WIDTH && pos < FLIP_LIMIT) begin
            c[pos - `ECC_DATA_WIDTH] = ~c[pos - `ECC_DATA_WIDTH];
        end
    endtask

    task automatic finish_pending();
        if (pend_valid) begin
            compare("out_valid", out_valid, 1'b1);
            compare("data_out", data_out, pend_exp.data);
            compare("sbit_err", sbit_err, pend_exp.sbit);
            compare("dbit_err", dbit_err, pend_exp.dbit);
            tests_run++;
            if (errors == pend_errors) begin
                $display("test %s: ok", pend_name);
            end else begin
                $display("test %s: mismatch", pend_name);
                tests_failed++;
            end
        end else begin
            compare("out_valid", out_valid, 1'b0);
        end
        pend_valid = 1'b0;
    endtask

    // One input slot; outputs are sampled on the falling edge, where they are stable.
    task automatic present(input logic valid, input string name, input ecc_data_t d,
                           input ecc_check_t c, input logic byp,
                           input ecc_check_t exp_check, input expect_t exp);
        @(posedge clk);
        #2;
        in_valid = valid;
        data_in  = d;
        check_in = c;
        bypass   = byp;
        @(negedge clk);
        finish_pending();
        if (valid) begin
            pend_errors = errors;
            compare("check_out", check_out, exp_check);
            pend_valid = 1'b1;
            pend_name  = name;
            pend_exp   = exp;
        end
    endtask

    task automatic idle();
        present(1'b0, "", '0, '0, 1'b0, '0, '0);
    endtask

    task automatic run_line(input ecc_data_t d, input ecc_check_t c, input integer fa,
                            input integer fb, input integer byp, input integer line_no);
        ecc_data_t  bad_d;
        ecc_check_t bad_c;
        expect_t    exp;
        integer     flips;
        string      kind;
        present(1'b1, $sformatf("line %0d clean", line_no), d, c, 1'b0, c,
                make_expect(d, 1'b0, 1'b0));
        if (fa >= 0 || fb >= 0 || byp != 0) begin
            bad_d = d;
            bad_c = c;
            apply_flip(fa, bad_d, bad_c);
            if (fb != fa) begin
                apply_flip(fb, bad_d, bad_c);
            end
            flips = 0;
            if (fa >= 0) begin
                flips++;
            end
            if (fb >= 0 && fb != fa) begin
                flips++;
            end
            if (byp != 0) begin
                kind = "bypass";
                exp  = make_expect(bad_d, 1'b0, 1'b0);
            end else if (flips == 2) begin
                kind = "double";
                exp  = make_expect(bad_d, 1'b0, 1'b1);   // Uncorrectable, data passes as is.
            end else begin
                kind = (fa >= `ECC_DATA_WIDTH || fb >= `ECC_DATA_WIDTH) ? "check bit" : "single";
                exp  = make_expect(d, 1'b1, 1'b0);
            end
            present(1'b1, $sformatf("line %0d %s", line_no, kind), bad_d, bad_c,
                    (byp != 0), encode(bad_d), exp);
        end
    endtask

    task automatic run_file(input integer fd);
        logic [8*256-1:0] line_buf;
        integer           code;
        integer           n;
        integer           fa;
        integer           fb;
        integer           byp;
        integer           line_no;
        ecc_data_t        d;
        ecc_check_t       c;
        line_no = 0;
        while (!$feof(fd) && line_no < MAX_LINES) begin
            line_buf = '0;
            code = $fgets(line_buf, fd);
            line_no++;
            if (code > 0) begin
                n = $sscanf(line_buf, "%h %h %d %d %d", d, c, fa, fb, byp);
                if (n == 5) begin   // Comment and blank lines fail the scan.
                    words_read++;
                    run_line(d, c, fa, fb, byp, line_no);
                end
            end
        end
    endtask

    task automatic run_random(input integer n);
        logic [127:0] raw;
        ecc_data_t    d;
        ecc_data_t    bad_d;
        ecc_check_t   c;
        ecc_check_t   bad_c;
        integer       pos;
        raw = {$random(seed), $random(seed), $random(seed), $random(seed)};
        d   = raw[`ECC_DATA_WIDTH-1:0];
        c   = encode(d);
        pos = $unsigned($random(seed)) % FLIP_LIMIT;
        bad_d = d;
        bad_c = c;
        apply_flip(pos, bad_d, bad_c);
        present(1'b1, $sformatf("random %0d flip %0d", n, pos), bad_d, bad_c, 1'b0,
                encode(bad_d), make_expect(d, 1'b1, 1'b0));
    endtask

    task automatic abort_run(input string reason);
        $display("Run stopped: %s", reason);
        $display("Test failures found");
        $finish;
    endtask

    task automatic report();
        $display("tests run %0d, tests failed %0d, mismatches %0d",
                 tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    endtask

    initial begin
        integer fd;
        integer i;
        integer wait_count;
        integer reset_errors;
        clk          = 1'b0;
        arst_n       = 1'b0;
        in_valid     = 1'b0;
        data_in      = '0;
        check_in     = '0;
        bypass       = 1'b0;
        seed         = 55966;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        words_read   = 0;
        pend_valid   = 1'b0;
        pend_errors  = 0;
        build_columns();

        reset_errors = errors;
        for (i = 0; i < 10; i++) begin
            @(negedge clk);
            compare("out_valid", out_valid, 1'b0);
        end
        @(posedge clk);
        #2;
        arst_n = 1'b1;
        idle();
        idle();
        tests_run++;
        if (errors == reset_errors) begin
            $display("test reset: ok");
        end else begin
            $display("test reset: mismatch");
            tests_failed++;
        end

        fd = $fopen("testbench/ecc_stim.txt", "r");
        if (fd == 0) begin
            abort_run("cannot open testbench/ecc_stim.txt");
        end else begin
            run_file(fd);
            $fclose(fd);
            if (words_read == 0) begin
                $display("The stimulus file held no words");
                errors++;
            end
            idle();
            for (i = 0; i < RANDOM_WORDS; i++) begin
                run_random(i);
            end
            idle();
            wait_count = 0;
            while (out_valid !== 1'b0 && wait_count < WAIT_LIMIT) begin
                @(negedge clk);
                wait_count++;
            end
            if (out_valid !== 1'b0) begin
                abort_run("timeout, out_valid stayed high after the last word");
            end else begin
                report();
            end
        end
    end

endmodule
